// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = xt_glue_tb
FILELIST  = xt_glue.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "Test OK" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: src/xt_bus_pkg.sv
// I/O bus definitions for the XT glue block
// port address width, data byte and register offset types
// block numbers decoded from address bits 7:5

package xt_bus_pkg;

    // 10-bit XT I/O port space
    localparam int IO_ADDR_W = 10;

    // one byte on the data bus
    typedef logic [7:0] byte_t;

    // register offset inside a device block, address bits 1:0
    typedef logic [1:0] io_offset_t;

    // 32-port blocks selected by address bits 7:5
    localparam logic [2:0] PIC_BLOCK = 3'd1;
    localparam logic [2:0] PIT_BLOCK = 3'd2;
    localparam logic [2:0] PPI_BLOCK = 3'd3;

endpackage

// File: src/xt_glue_top.sv
// XT peripheral glue top level
// bus decode block plus interrupt latch, interval timer and
// parallel-port keyboard block

`timescale 1ns/10ps

module xt_glue_top #(
    parameter int                PIT_PRESCALE = 4,
    parameter xt_bus_pkg::byte_t VECTOR_BASE  = 8'h08
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [xt_bus_pkg::IO_ADDR_W-1:0]  address,
    input  xt_bus_pkg::byte_t                 data_in,
    input  logic                              io_read_n,
    input  logic                              io_write_n,
    input  logic                              address_enable_n,
    input  logic                              interrupt_acknowledge_n,
    input  logic [xt_port_pkg::IRQ_LINES-1:2] interrupt_request,
    input  logic                              key_valid,
    input  xt_bus_pkg::byte_t                 key_code,
    input  xt_bus_pkg::byte_t                 port_c_in,
    output xt_bus_pkg::byte_t                 data_bus_out,
    output logic                              data_bus_out_from_chipset,
    output logic                              interrupt_to_cpu,
    output logic                              timer_out0,
    output logic                              timer_out2,
    output logic                              speaker_out,
    output xt_bus_pkg::byte_t                 port_b_out,
    output logic                              kbd_reset_request
);
    import xt_bus_pkg::*;

    logic       pic_select_n;
    logic       pit_select_n;
    logic       ppi_select_n;
    io_offset_t offset;
    logic       write_strobe;
    byte_t      pic_data;
    byte_t      pic_vector;
    byte_t      ppi_data;
    logic       timer2_gate;
    logic       speaker_data;
    logic       keyboard_irq;

    xt_io_bus u_io_bus (
        .clock                     (clock),
        .reset                     (reset),
        .address                   (address),
        .address_enable_n          (address_enable_n),
        .io_read_n                 (io_read_n),
        .io_write_n                (io_write_n),
        .interrupt_acknowledge_n   (interrupt_acknowledge_n),
        .pic_data                  (pic_data),
        .pic_vector                (pic_vector),
        .ppi_data                  (ppi_data),
        .pic_select_n              (pic_select_n),
        .pit_select_n              (pit_select_n),
        .ppi_select_n              (ppi_select_n),
        .offset                    (offset),
        .write_strobe              (write_strobe),
        .data_bus_out              (data_bus_out),
        .data_bus_out_from_chipset (data_bus_out_from_chipset)
    );

    xt_pic #(
        .VECTOR_BASE (VECTOR_BASE)
    ) u_pic (
        .clock             (clock),
        .reset             (reset),
        .select_n          (pic_select_n),
        .write_strobe      (write_strobe),
        .offset            (offset),
        .data_in           (data_in),
        .timer_irq         (timer_out0),
        .keyboard_irq      (keyboard_irq),
        .interrupt_request (interrupt_request),
        .read_data         (pic_data),
        .vector            (pic_vector),
        .interrupt_to_cpu  (interrupt_to_cpu)
    );

    xt_pit #(
        .PIT_PRESCALE (PIT_PRESCALE)
    ) u_pit (
        .clock        (clock),
        .reset        (reset),
        .select_n     (pit_select_n),
        .write_strobe (write_strobe),
        .offset       (offset),
        .data_in      (data_in),
        .timer2_gate  (timer2_gate),
        .speaker_data (speaker_data),
        .timer_out0   (timer_out0),
        .timer_out2   (timer_out2),
        .speaker_out  (speaker_out)
    );

    xt_ppi_keyboard u_ppi (
        .clock             (clock),
        .reset             (reset),
        .select_n          (ppi_select_n),
        .write_strobe      (write_strobe),
        .offset            (offset),
        .data_in           (data_in),
        .key_valid         (key_valid),
        .key_code          (key_code),
        .port_c_in         (port_c_in),
        .read_data         (ppi_data),
        .port_b_out        (port_b_out),
        .timer2_gate       (timer2_gate),
        .speaker_data      (speaker_data),
        .keyboard_irq      (keyboard_irq),
        .kbd_reset_request (kbd_reset_request)
    );

endmodule

// File: src/xt_io_bus.sv
// I/O bus block: XT address decode, write strobe from the
// falling edge of io_write_n, and the priority read-return mux

`timescale 1ns/10ps

module xt_io_bus (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [xt_bus_pkg::IO_ADDR_W-1:0] address,
    input  logic                             address_enable_n,
    input  logic                             io_read_n,
    input  logic                             io_write_n,
    input  logic                             interrupt_acknowledge_n,
    input  xt_bus_pkg::byte_t                pic_data,
    input  xt_bus_pkg::byte_t                pic_vector,
    input  xt_bus_pkg::byte_t                ppi_data,
    output logic                             pic_select_n,
    output logic                             pit_select_n,
    output logic                             ppi_select_n,
    output xt_bus_pkg::io_offset_t           offset,
    output logic                             write_strobe,
    output xt_bus_pkg::byte_t                data_bus_out,
    output logic                             data_bus_out_from_chipset
);
    import xt_bus_pkg::*;

    logic       io_write_n_prev;
    logic       io_space;
    logic [2:0] block;

    // only ports below 0x100 with AEN low belong to the XT blocks
    assign io_space = ~address_enable_n & (address[IO_ADDR_W-1:8] == '0);
    assign block    = address[7:5];

    assign pic_select_n = ~(io_space & (block == PIC_BLOCK));
    assign pit_select_n = ~(io_space & (block == PIT_BLOCK));
    assign ppi_select_n = ~(io_space & (block == PPI_BLOCK));

    assign offset = address[1:0];

    // previous write strobe level for edge detection
    always_ff @(posedge clock) begin
        if (reset) begin
            io_write_n_prev <= 1'b1;
        end else begin
            io_write_n_prev <= io_write_n;
        end
    end

    // high only in the first low cycle of io_write_n
    assign write_strobe = io_write_n_prev & ~io_write_n;

    // read return, acknowledge has the highest priority
    always_comb begin
        if (~interrupt_acknowledge_n) begin
            data_bus_out_from_chipset = 1'b1;
            data_bus_out              = pic_vector;
        end else if (~pic_select_n && ~io_read_n) begin
            data_bus_out_from_chipset = 1'b1;
            data_bus_out              = pic_data;
        end else if (~ppi_select_n && ~io_read_n) begin
            data_bus_out_from_chipset = 1'b1;
            data_bus_out              = ppi_data;
        end else begin
            data_bus_out_from_chipset = 1'b0;
            data_bus_out              = 8'h00;
        end
    end

endmodule

// File: src/xt_pic.sv
// reduced 8259 interrupt latch: edge capture into pending bits,
// mask register, end-of-interrupt clear and vector generation

`timescale 1ns/10ps

module xt_pic #(
    parameter xt_bus_pkg::byte_t VECTOR_BASE = 8'h08
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              select_n,
    input  logic                              write_strobe,
    input  xt_bus_pkg::io_offset_t            offset,
    input  xt_bus_pkg::byte_t                 data_in,
    input  logic                              timer_irq,
    input  logic                              keyboard_irq,
    input  logic [xt_port_pkg::IRQ_LINES-1:2] interrupt_request,
    output xt_bus_pkg::byte_t                 read_data,
    output xt_bus_pkg::byte_t                 vector,
    output logic                              interrupt_to_cpu
);
    import xt_bus_pkg::*;
    import xt_port_pkg::*;

    localparam int LINE_W = $clog2(IRQ_LINES);

    logic [IRQ_LINES-1:0] lines;
    logic [IRQ_LINES-1:0] lines_prev;
    logic [IRQ_LINES-1:0] pending;
    logic [IRQ_LINES-1:0] mask;
    logic [IRQ_LINES-1:0] active;
    logic [LINE_W-1:0]    lowest_line;
    logic                 write_en;

    assign lines[IRQ_TIMER]           = timer_irq;
    assign lines[IRQ_KEYBOARD]        = keyboard_irq;
    assign lines[IRQ_LINES-1:2]       = interrupt_request;

    // A0 picks pending (0) or mask (1)
    assign write_en = write_strobe & ~select_n;

    always_ff @(posedge clock) begin
        if (reset) begin
            // all ones so lines already high at reset are not seen as edges
            lines_prev <= '1;
            pending    <= '0;
            mask       <= '1;
        end else begin
            lines_prev <= lines;
            if (write_en && ~offset[0]) begin
                // EOI clears the selected bits, a new edge still wins
                pending <= (pending & ~data_in) | (lines & ~lines_prev);
            end else begin
                pending <= pending | (lines & ~lines_prev);
            end
            if (write_en && offset[0]) begin
                mask <= data_in;
            end
        end
    end

    assign active           = pending & ~mask;
    assign interrupt_to_cpu = |active;

    // lowest numbered unmasked request
    always_comb begin
        lowest_line = '0;
        for (int i = IRQ_LINES - 1; i >= 0; i--) begin
            if (active[i]) begin
                lowest_line = LINE_W'(i);
            end
        end
    end

    assign vector    = VECTOR_BASE + byte_t'(lowest_line);
    assign read_data = offset[0] ? mask : pending;

endmodule

// File: src/xt_pit.sv
// interval timer: tick prescaler and two reloadable square-wave
// channels (0 at offset 0, 2 at offset 2), speaker output gating

`timescale 1ns/10ps

module xt_pit #(
    parameter int PIT_PRESCALE = 4
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   select_n,
    input  logic                   write_strobe,
    input  xt_bus_pkg::io_offset_t offset,
    input  xt_bus_pkg::byte_t      data_in,
    input  logic                   timer2_gate,
    input  logic                   speaker_data,
    output logic                   timer_out0,
    output logic                   timer_out2,
    output logic                   speaker_out
);
    import xt_bus_pkg::*;

    localparam int PRE_W = $clog2(PIT_PRESCALE);

    logic [PRE_W-1:0] prescale_count;
    logic             tick;
    logic [1:0]       chan_gate;
    logic [1:0]       chan_out;

    // one tick every PIT_PRESCALE clocks
    assign tick = (prescale_count == PRE_W'(PIT_PRESCALE - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            prescale_count <= '0;
        end else if (tick) begin
            prescale_count <= '0;
        end else begin
            prescale_count <= prescale_count + 1'b1;
        end
    end

    // channel 0 runs freely
    assign chan_gate = {timer2_gate, 1'b1};

    for (genvar c = 0; c < 2; c++) begin : g_chan
        localparam io_offset_t CHAN_OFFSET = io_offset_t'(2 * c);

        logic [15:0] reload;
        logic [15:0] count;
        logic        high_byte;
        logic        load_pending;
        logic        running;
        logic        out_q;
        logic        chan_write;
        logic        terminal;

        assign chan_write = write_strobe & ~select_n & (offset == CHAN_OFFSET);
        assign terminal   = running & ~load_pending & (count == 16'd1);

        // low byte first, then high byte
        always_ff @(posedge clock) begin
            if (chan_write) begin
                if (high_byte) begin
                    reload[15:8] <= data_in;
                end else begin
                    reload[7:0] <= data_in;
                end
            end
        end

        // a reload of 0 wraps through 0xffff, giving 65536 ticks
        always_ff @(posedge clock) begin
            if (tick) begin
                if (load_pending) begin
                    count <= reload;
                end else if (running && chan_gate[c]) begin
                    count <= (count == 16'd1) ? reload : count - 16'd1;
                end
            end
        end

        always_ff @(posedge clock) begin
            if (reset) begin
                high_byte    <= 1'b0;
                load_pending <= 1'b0;
                running      <= 1'b0;
                out_q        <= 1'b1;
            end else begin
                if (tick && load_pending) begin
                    load_pending <= 1'b0;
                    running      <= 1'b1;
                end
                // high byte write arms the load for the next tick
                if (chan_write) begin
                    high_byte <= ~high_byte;
                    if (high_byte) begin
                        load_pending <= 1'b1;
                    end
                end
                if (!chan_gate[c] || (tick && load_pending)) begin
                    out_q <= 1'b1;
                end else if (tick && terminal) begin
                    out_q <= ~out_q;
                end
            end
        end

        assign chan_out[c] = out_q;
    end

    assign timer_out0  = chan_out[0];
    assign timer_out2  = chan_out[1];
    assign speaker_out = timer_out2 & speaker_data;

endmodule

// File: src/xt_port_pkg.sv
// peripheral port definitions for the XT glue block
// port B control word with byte and field views, IRQ line numbers

package xt_port_pkg;

    // named bits of the port B control latch
    typedef struct packed {
        logic       clear_keycode;
        logic       keyboard_enable;
        logic [3:0] spare;
        logic       speaker_data;
        logic       timer2_gate;
    } port_b_fields_t;

    // raw byte for bus write and read-back, fields for the devices
    typedef union packed {
        xt_bus_pkg::byte_t raw;
        port_b_fields_t    field;
    } port_b_ctrl_u;

    // fixed interrupt lines
    localparam int IRQ_TIMER    = 0;
    localparam int IRQ_KEYBOARD = 1;
    localparam int IRQ_LINES    = 8;

endpackage

// File: src/xt_ppi_keyboard.sv
// parallel port block: port A scan-code latch, port B control
// latch with its decoded bits, port C input, keyboard reset pulse

`timescale 1ns/10ps

module xt_ppi_keyboard (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   select_n,
    input  logic                   write_strobe,
    input  xt_bus_pkg::io_offset_t offset,
    input  xt_bus_pkg::byte_t      data_in,
    input  logic                   key_valid,
    input  xt_bus_pkg::byte_t      key_code,
    input  xt_bus_pkg::byte_t      port_c_in,
    output xt_bus_pkg::byte_t      read_data,
    output xt_bus_pkg::byte_t      port_b_out,
    output logic                   timer2_gate,
    output logic                   speaker_data,
    output logic                   keyboard_irq,
    output logic                   kbd_reset_request
);
    import xt_port_pkg::*;

    port_b_ctrl_u port_b;
    logic [7:0]   key_latch;
    logic         keyboard_enable_prev;

    // port B is the only writable register
    always_ff @(posedge clock) begin
        if (reset) begin
            port_b.raw <= 8'h00;
        end else if (write_strobe && ~select_n && (offset == 2'd1)) begin
            port_b.raw <= data_in;
        end
    end

    // one key held until software clears it
    always_ff @(posedge clock) begin
        if (reset) begin
            key_latch    <= 8'h00;
            keyboard_irq <= 1'b0;
        end else if (port_b.field.clear_keycode) begin
            key_latch    <= 8'h00;
            keyboard_irq <= 1'b0;
        end else if (key_valid && !keyboard_irq) begin
            key_latch    <= key_code;
            keyboard_irq <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            keyboard_enable_prev <= 1'b0;
        end else begin
            keyboard_enable_prev <= port_b.field.keyboard_enable;
        end
    end

    // rising edge of keyboard enable requests a keyboard reset
    assign kbd_reset_request = port_b.field.keyboard_enable & ~keyboard_enable_prev;

    assign port_b_out   = port_b.raw;
    assign timer2_gate  = port_b.field.timer2_gate;
    assign speaker_data = port_b.field.speaker_data;

    always_comb begin
        case (offset)
            2'd0:    read_data = key_latch;
            2'd1:    read_data = port_b.raw;
            2'd2:    read_data = port_c_in;
            // no control word read-back
            default: read_data = 8'hFF;
        endcase
    end

endmodule

// File: verification/xt_glue_clock.sv
// testbench clock source
// free-running square wave, 10 ns period by default

`timescale 1ns/10ps

module xt_glue_clock #(
    parameter int HALF_PERIOD = 5
) (
    output logic clock
);
    initial begin
        clock = 1'b0;
        forever begin
            #(HALF_PERIOD) clock = ~clock;
        end
    end
endmodule

// File: verification/xt_glue_properties.sv
// concurrent checks bound to the glue top level
// bus drive qualification, keyboard reset pulse width, masked interrupt

`timescale 1ns/10ps

module xt_glue_properties (
    input logic       clock,
    input logic       reset,
    input logic       io_read_n,
    input logic       interrupt_acknowledge_n,
    input logic       pic_select_n,
    input logic       ppi_select_n,
    input logic       data_bus_out_from_chipset,
    input logic       kbd_reset_request,
    input logic       interrupt_to_cpu,
    input logic [7:0] mask
);
    int assert_failures = 0;

    // chipset drives only for a claimed read or an acknowledge
    bus_drive_claimed: assert property (@(posedge clock) disable iff (reset)
        data_bus_out_from_chipset |-> (~interrupt_acknowledge_n
            || (~io_read_n && (~pic_select_n || ~ppi_select_n))))
        else begin
            assert_failures++;
            $error("data bus driven without a selected read or an acknowledge");
        end

    kbd_reset_single_cycle: assert property (@(posedge clock) disable iff (reset)
        kbd_reset_request |=> !kbd_reset_request)
        else begin
            assert_failures++;
            $error("kbd_reset_request held for more than one cycle");
        end

    // everything masked means no request to the cpu
    masked_irq_quiet: assert property (@(posedge clock) disable iff (reset)
        (mask == 8'hFF) |-> !interrupt_to_cpu)
        else begin
            assert_failures++;
            $error("interrupt_to_cpu high with all lines masked");
        end

endmodule

// File: verification/xt_glue_tb.sv
// testbench for the XT glue block
// replays records from the tests file over the I/O bus
// and checks read data, interrupts, tone timing and keyboard reset

`timescale 1ns/10ps

module xt_glue_tb;
    localparam int         PIT_PRESCALE = 4;
    localparam logic [7:0] VECTOR_BASE  = 8'h08;
    localparam int         MAX_RECORDS  = 64;
    localparam int         IDLE_CYCLES  = 4;

    logic       clock;
    logic       reset;
    logic [9:0] address;
    logic [7:0] data_in;
    logic       io_read_n;
    logic       io_write_n;
    logic       address_enable_n;
    logic       interrupt_acknowledge_n;
    logic [7:2] interrupt_request;
    logic       key_valid;
    logic [7:0] key_code;
    logic [7:0] port_c_in;
    logic [7:0] data_bus_out;
    logic       data_bus_out_from_chipset;
    logic       interrupt_to_cpu;
    logic       timer_out0;
    logic       timer_out2;
    logic       speaker_out;
    logic [7:0] port_b_out;
    logic       kbd_reset_request;

    logic [47:0] records [MAX_RECORDS];
    int          num_records;
    int          record_errors;
    int          reset_pulses;
    bit          loaded;

    xt_glue_clock u_clock (
        .clock (clock)
    );

    xt_glue_top #(
        .PIT_PRESCALE (PIT_PRESCALE),
        .VECTOR_BASE  (VECTOR_BASE)
    ) uut (
        .clock                     (clock),
        .reset                     (reset),
        .address                   (address),
        .data_in                   (data_in),
        .io_read_n                 (io_read_n),
        .io_write_n                (io_write_n),
        .address_enable_n          (address_enable_n),
        .interrupt_acknowledge_n   (interrupt_acknowledge_n),
        .interrupt_request         (interrupt_request),
        .key_valid                 (key_valid),
        .key_code                  (key_code),
        .port_c_in                 (port_c_in),
        .data_bus_out              (data_bus_out),
        .data_bus_out_from_chipset (data_bus_out_from_chipset),
        .interrupt_to_cpu          (interrupt_to_cpu),
        .timer_out0                (timer_out0),
        .timer_out2                (timer_out2),
        .speaker_out               (speaker_out),
        .port_b_out                (port_b_out),
        .kbd_reset_request         (kbd_reset_request)
    );

    bind xt_glue_top xt_glue_properties u_properties (
        .clock                     (clock),
        .reset                     (reset),
        .io_read_n                 (io_read_n),
        .interrupt_acknowledge_n   (interrupt_acknowledge_n),
        .pic_select_n              (pic_select_n),
        .ppi_select_n              (ppi_select_n),
        .data_bus_out_from_chipset (data_bus_out_from_chipset),
        .kbd_reset_request         (kbd_reset_request),
        .interrupt_to_cpu          (interrupt_to_cpu),
        .mask                      (u_pic.mask)
    );

    // keyboard reset pulses seen so far
    always @(negedge clock) begin
        if (!reset && kbd_reset_request) begin
            reset_pulses <= reset_pulses + 1;
        end
    end

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("FAILED at %0d ns: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            record_errors++;
        end
    endtask

    // io_write_n held low for three cycles yet only one write is taken
    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge clock);
        address          <= addr[9:0];
        address_enable_n <= addr[15];
        data_in          <= data;
        io_write_n       <= 1'b0;
        repeat (3) @(posedge clock);
        io_write_n       <= 1'b1;
        address_enable_n <= 1'b0;
        @(negedge clock);
        // port B latch shows up on its output pins
        if (addr == 16'h0061) begin
            check_value("port_b_out", int'(port_b_out), int'(data));
        end
    endtask

    // expected bit 8 set means nobody may drive the bus
    task automatic bus_read(input logic [15:0] addr, input logic [8:0] expected);
        @(posedge clock);
        address          <= addr[9:0];
        address_enable_n <= addr[15];
        io_read_n        <= 1'b0;
        @(negedge clock);
        if (expected[8]) begin
            check_value("data_bus_out_from_chipset", int'(data_bus_out_from_chipset), 0);
            check_value("data_bus_out", int'(data_bus_out), 0);
        end else begin
            check_value("data_bus_out_from_chipset", int'(data_bus_out_from_chipset), 1);
            check_value("data_bus_out", int'(data_bus_out), int'(expected[7:0]));
        end
        @(posedge clock);
        io_read_n        <= 1'b1;
        address_enable_n <= 1'b0;
    endtask

    task automatic key_strobe(input logic [7:0] code);
        @(posedge clock);
        key_code  <= code;
        key_valid <= 1'b1;
        @(posedge clock);
        key_valid <= 1'b0;
    endtask

    task automatic set_irq_lines(input logic [7:0] lines, input logic expected);
        @(posedge clock);
        interrupt_request <= lines[7:2];
        repeat (2) @(posedge clock);
        @(negedge clock);
        check_value("interrupt_to_cpu", int'(interrupt_to_cpu), int'(expected));
    endtask

    task automatic acknowledge(input logic [7:0] expected);
        @(posedge clock);
        interrupt_acknowledge_n <= 1'b0;
        @(negedge clock);
        check_value("data_bus_out_from_chipset", int'(data_bus_out_from_chipset), 1);
        check_value("data_bus_out", int'(data_bus_out), int'(expected));
        @(posedge clock);
        interrupt_acknowledge_n <= 1'b1;
    endtask

    // cycles until the next rising edge of speaker_out
    task automatic measure_rise(input int limit, output int cycles);
        logic prev;
        prev   = speaker_out;
        cycles = 0;
        while (cycles < limit) begin
            @(negedge clock);
            cycles++;
            if (speaker_out && !prev) begin
                return;
            end
            prev = speaker_out;
        end
        $display("speaker_out did not rise within %0d cycles", limit);
        record_errors++;
    endtask

    task automatic tone(input logic [15:0] reload, input int half);
        int interval;
        int i;
        bus_write(16'h0061, 8'h03);
        bus_write(16'h0042, reload[7:0]);
        bus_write(16'h0042, reload[15:8]);
        // first edge only aligns to the waveform
        measure_rise(4 * half + 32, interval);
        for (i = 0; i < 2; i++) begin
            measure_rise(4 * half + 32, interval);
            check_value("speaker_out period", interval, 2 * half);
        end
        // gate low with the speaker on
        bus_write(16'h0061, 8'h02);
        for (i = 0; i < 4 * half; i++) begin
            @(negedge clock);
            check_value("speaker_out", int'(speaker_out), 1);
            check_value("timer_out2", int'(timer_out2), 1);
            // channel 0 is never loaded and keeps its reset level
            check_value("timer_out0", int'(timer_out0), 1);
        end
        bus_write(16'h0061, 8'h00);
    endtask

    initial begin
        wait (loaded);
        repeat (num_records * 3000) @(posedge clock);
        $display("timeout: the tests did not finish within %0d cycles", num_records * 3000);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        logic [7:0]  op;
        logic [15:0] a;
        logic [23:0] b;
        int          pulses_before;
        int          passed;
        int          failed;
        int          assertion_errors;
        reset                   = 1'b1;
        address                 = '0;
        data_in                 = 8'h00;
        io_read_n               = 1'b1;
        io_write_n              = 1'b1;
        address_enable_n        = 1'b0;
        interrupt_acknowledge_n = 1'b1;
        interrupt_request       = '0;
        key_valid               = 1'b0;
        key_code                = 8'h00;
        port_c_in               = 8'hA5;
        reset_pulses            = 0;
        passed                  = 0;
        failed                  = 0;
        for (int i = 0; i < MAX_RECORDS; i++) begin
            records[i] = '0;
        end
        $readmemh("verification/xt_glue_tests.txt", records);
        num_records = 0;
        while (num_records < MAX_RECORDS && records[num_records][47:40] != 8'h00) begin
            num_records++;
        end
        loaded = 1'b1;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        for (int r = 0; r < num_records; r++) begin
            op            = records[r][47:40];
            a             = records[r][39:24];
            b             = records[r][23:0];
            record_errors = 0;
            pulses_before = reset_pulses;
            case (op)
                8'd1: bus_write(a, b[7:0]);
                8'd2: bus_read(a, b[8:0]);
                8'd3: key_strobe(a[7:0]);
                8'd4: set_irq_lines(a[7:0], b[0]);
                8'd5: tone(a, int'(b));
                8'd6: acknowledge(b[7:0]);
                default: begin
                    $display("record %0d holds an unknown operation %0d", r, op);
                    record_errors++;
                end
            endcase
            repeat (IDLE_CYCLES) @(posedge clock);
            if (op == 8'd1) begin
                check_value("kbd_reset_request pulses", reset_pulses - pulses_before,
                            int'(b[11:8]));
            end
            if (record_errors == 0) begin
                passed++;
                $display("record %0d op %0d passed", r, op);
            end else begin
                failed++;
                $display("record %0d op %0d failed with %0d errors", r, op, record_errors);
            end
        end
        assertion_errors = uut.u_properties.assert_failures;
        $display("%0d records passed, %0d failed, %0d assertion failures",
                 passed, failed, assertion_errors);
        if (failed == 0 && assertion_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verification/xt_glue_tests.txt
// columns are op _ a _ b in hex, one record per line
// 01 write   a = port, b = data with expected keyboard reset pulses in bits 11:8
// 02 read    a = port with AEN high in bit 15, b = expected byte or 100 for no drive
// 03 key     a = scan code; 04 irq a = request lines, b = expected interrupt_to_cpu
// 05 tone    a = reload, b = half period in clocks; 06 acknowledge b = expected vector
01_0061_000030
02_0061_000030
02_0062_0000A5
02_00A0_000100
02_8061_000100
01_0061_000000
03_001C_000000
02_0060_00001C
02_0020_000002
03_002A_000000
02_0060_00001C
01_0061_000080
02_0060_000000
01_0061_000000
01_0020_000002
01_0021_000000
04_0020_000001
02_0020_000020
06_0000_00000D
01_0020_000020
04_0000_000000
05_0010_000040
01_0061_000140
01_0061_000000

// File: xt_glue.f
src/xt_bus_pkg.sv
src/xt_port_pkg.sv
src/xt_io_bus.sv
src/xt_pic.sv
src/xt_pit.sv
src/xt_ppi_keyboard.sv
src/xt_glue_top.sv
verification/xt_glue_clock.sv
verification/xt_glue_properties.sv
verification/xt_glue_tb.sv
